// ==== common/cpu_settings.svh ====
// Core-wide settings for the word width, register count and reset address.
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// data and address bus width.
`define CPU_WORD_WIDTH 16

// general registers, r0 reads as zero.
`define CPU_REG_COUNT 8

// first fetch address.
`define CPU_RESET_PC 16'h0000

`endif

// ==== common/cpuTypes.sv ====
// Package of the word, opcode, flag and control-word types shared by the core.
`include "cpu_settings.svh"

package cpuTypes;

  typedef logic [`CPU_WORD_WIDTH-1:0] word_t;
  typedef logic [`CPU_WORD_WIDTH-1:0] addr_t;  // word address.
  typedef logic [$clog2(`CPU_REG_COUNT)-1:0] regIndex_t;

  // instruction bits 15:12.
  typedef enum logic [3:0] {
    OP_ADD  = 4'h0,
    OP_SUB  = 4'h1,
    OP_AND  = 4'h2,
    OP_OR   = 4'h3,
    OP_XOR  = 4'h4,
    OP_ADDI = 4'h5,
    OP_LUI  = 4'h6,
    OP_LDW  = 4'h7,
    OP_STW  = 4'h8,
    OP_BR   = 4'h9
  } opcode_t;

  // branch condition in bits 11:9.
  typedef enum logic [2:0] {
    BR_ALWAYS = 3'd0,
    BR_EQ     = 3'd1,
    BR_NE     = 3'd2,
    BR_CS     = 3'd3,
    BR_MI     = 3'd4
  } brCond_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASSB
  } aluOp_t;

  typedef struct packed {
    logic z;
    logic n;
    logic c;
    logic v;
  } flags_t;

  typedef logic [1:0] busSel_t;
  localparam busSel_t BUS_PC  = 2'd0;
  localparam busSel_t BUS_RS1 = 2'd1;
  localparam busSel_t BUS_RS2 = 2'd2;  // store data held in the mdr.

  typedef struct packed {
    aluOp_t  aluOp;
    logic    opBSel;      // 0 register, 1 immediate.
    logic    immUpper;    // 0 sign-extended, 1 shifted up by 8.
    logic    regWrite;
    logic    wbSel;       // 0 alu, 1 memory.
    logic    flagsWrite;
    logic    irWrite;
    logic    mdrWrite;
    logic    pcWrite;
    logic    pcSel;       // 0 increment, 1 branch.
    busSel_t busSel;
  } controlWord_t;

endpackage

// ==== datapath/alu.sv ====
// ALU doing add, subtract, logic and pass-B, and forming the Z, N, C and V flags.
`timescale 1ns/1ps

module alu (
  input  cpuTypes::aluOp_t op,
  input  cpuTypes::word_t  a,
  input  cpuTypes::word_t  b,
  output cpuTypes::word_t  result,
  output cpuTypes::flags_t flagsOut
);

  localparam int msb = $bits(cpuTypes::word_t) - 1;

  logic [msb+1:0] sum;  // top bit is the carry.
  logic           overflow;

  always_comb begin
    sum = '0;
    overflow = 1'b0;
    case (op)
      cpuTypes::ALU_ADD: begin
        sum = {1'b0, a} + {1'b0, b};
        overflow = (a[msb] == b[msb]) && (sum[msb] != a[msb]);
      end
      cpuTypes::ALU_SUB: begin
        sum = {1'b0, a} + {1'b0, ~b} + 1'b1;  // carry set means no borrow.
        overflow = (a[msb] != b[msb]) && (sum[msb] != a[msb]);
      end
      cpuTypes::ALU_AND: sum = {1'b0, a & b};
      cpuTypes::ALU_OR:  sum = {1'b0, a | b};
      cpuTypes::ALU_XOR: sum = {1'b0, a ^ b};
      default:           sum = {1'b0, b};
    endcase
  end

  assign result = sum[msb:0];

  assign flagsOut.z = (result == '0);
  assign flagsOut.n = result[msb];
  assign flagsOut.c = sum[msb+1];  // zero for logic ops.
  assign flagsOut.v = overflow;

endmodule

// ==== datapath/registerFile.sv ====
// Register file with two read ports, one write port and register 0 fixed at zero.
`timescale 1ns/1ps
`include "cpu_settings.svh"

module registerFile (
  input  logic                Clock,
  input  logic                reset,
  input  cpuTypes::regIndex_t readA,
  input  cpuTypes::regIndex_t readB,
  input  cpuTypes::regIndex_t writeIndex,
  input  logic                writeEnable,
  input  cpuTypes::word_t     writeData,
  output cpuTypes::word_t     dataA,
  output cpuTypes::word_t     dataB
);

  cpuTypes::word_t regs [`CPU_REG_COUNT];

  always_ff @(posedge Clock) begin
    if (reset) begin
      for (int i = 0; i < `CPU_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEnable && (writeIndex != '0)) begin
      regs[writeIndex] <= writeData;
    end
  end

  // r0 always reads zero.
  assign dataA = (readA == '0) ? '0 : regs[readA];
  assign dataB = (readB == '0) ? '0 : regs[readB];

endmodule

// ==== datapath/datapath.sv ====
// Datapath with the PC, instruction register, flags, store data and bus multiplexing.
`timescale 1ns/1ps
`include "cpu_settings.svh"

module datapath (
  input  logic                   Clock,
  input  logic                   reset,
  input  cpuTypes::controlWord_t ctrl,
  input  cpuTypes::word_t        dataIn,
  output cpuTypes::word_t        dataOut,
  output cpuTypes::word_t        instr,
  output cpuTypes::flags_t       flags
);

  cpuTypes::addr_t     pc;
  cpuTypes::word_t     ir;
  cpuTypes::word_t     mdr;
  cpuTypes::flags_t    flagsReg;
  cpuTypes::regIndex_t rd;
  cpuTypes::regIndex_t rs1;
  cpuTypes::regIndex_t rs2;
  cpuTypes::regIndex_t readAIndex;
  cpuTypes::word_t     imm;
  cpuTypes::word_t     regA;
  cpuTypes::word_t     regB;
  cpuTypes::word_t     aluB;
  cpuTypes::word_t     aluResult;
  cpuTypes::flags_t    aluFlags;
  cpuTypes::word_t     writeData;

  assign rd  = ir[11:9];
  assign rs1 = ir[8:6];
  assign rs2 = ir[5:3];

  // immediate forms take operand A from rd.
  assign readAIndex = ctrl.opBSel ? rd : rs1;

  assign imm = ctrl.immUpper ? {ir[7:0], 8'h00} : {{8{ir[7]}}, ir[7:0]};
  assign aluB = ctrl.opBSel ? imm : regB;
  assign writeData = ctrl.wbSel ? dataIn : aluResult;  // load data straight off the bus.

  registerFile registerFile (
    .Clock       (Clock         ),
    .reset       (reset         ),
    .readA       (readAIndex    ),
    .readB       (rs2           ),
    .writeIndex  (rd            ),
    .writeEnable (ctrl.regWrite ),
    .writeData   (writeData     ),
    .dataA       (regA          ),
    .dataB       (regB          )
  );

  alu alu (
    .op          (ctrl.aluOp    ),
    .a           (regA          ),
    .b           (aluB          ),
    .result      (aluResult     ),
    .flagsOut    (aluFlags      )
  );

  always_comb begin
    case (ctrl.busSel)
      cpuTypes::BUS_RS1: dataOut = regA;  // memory address.
      cpuTypes::BUS_RS2: dataOut = mdr;
      default:           dataOut = pc;
    endcase
  end

  always_ff @(posedge Clock) begin
    if (reset) begin
      pc <= `CPU_RESET_PC;
      flagsReg <= '0;
    end else begin
      if (ctrl.pcWrite) begin
        pc <= ctrl.pcSel ? pc + imm : pc + 1'b1;
      end
      if (ctrl.flagsWrite) begin
        flagsReg <= aluFlags;
      end
    end
  end

  always_ff @(posedge Clock) begin
    if (ctrl.irWrite) begin
      ir <= dataIn;
    end
    if (ctrl.mdrWrite) begin
      mdr <= regB;
    end
  end

  assign instr = ir;
  assign flags = flagsReg;

endmodule

// ==== control/control.sv ====
// Control unit sequencing fetch, execute and memory cycles on the multiplexed bus.
`timescale 1ns/1ps

module control (
  input  logic                   Clock,
  input  logic                   reset,
  input  cpuTypes::word_t        instr,
  input  cpuTypes::flags_t       flags,
  input  logic                   nWait,
  output cpuTypes::controlWord_t ctrl,
  output logic                   ale,
  output logic                   nMe,
  output logic                   nOe,
  output logic                   rnW,
  output logic                   enb
);

  typedef enum logic [2:0] {
    idle,
    fetchAddr,
    fetchData,
    execute,
    memAddr,
    memData
  } state_t;

  state_t state;
  state_t nextState;

  cpuTypes::opcode_t opcode;
  cpuTypes::brCond_t cond;
  cpuTypes::aluOp_t  regAluOp;
  logic              taken;
  logic              isStore;

  assign opcode  = cpuTypes::opcode_t'(instr[15:12]);
  assign cond    = cpuTypes::brCond_t'(instr[11:9]);
  assign isStore = (opcode == cpuTypes::OP_STW);

  always_comb begin
    case (opcode)
      cpuTypes::OP_SUB: regAluOp = cpuTypes::ALU_SUB;
      cpuTypes::OP_AND: regAluOp = cpuTypes::ALU_AND;
      cpuTypes::OP_OR:  regAluOp = cpuTypes::ALU_OR;
      cpuTypes::OP_XOR: regAluOp = cpuTypes::ALU_XOR;
      default:          regAluOp = cpuTypes::ALU_ADD;
    endcase
  end

  always_comb begin
    case (cond)
      cpuTypes::BR_ALWAYS: taken = 1'b1;
      cpuTypes::BR_EQ:     taken = flags.z;
      cpuTypes::BR_NE:     taken = !flags.z;
      cpuTypes::BR_CS:     taken = flags.c;
      cpuTypes::BR_MI:     taken = flags.n;
      default:             taken = 1'b0;  // unused codes never branch.
    endcase
  end

  always_ff @(posedge Clock) begin
    if (reset) begin
      state <= idle;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState   = state;
    ctrl        = '0;
    ctrl.aluOp  = cpuTypes::ALU_ADD;
    ctrl.busSel = cpuTypes::BUS_PC;
    ale = 1'b0;
    nMe = 1'b1;
    nOe = 1'b1;
    rnW = 1'b1;
    enb = 1'b0;
    case (state)
      idle: nextState = fetchAddr;
      fetchAddr: begin
        ale = 1'b1;
        nMe = 1'b0;
        ctrl.busSel = cpuTypes::BUS_PC;
        nextState = fetchData;
      end
      fetchData: begin
        nMe = 1'b0;
        nOe = 1'b0;
        if (nWait) begin
          ctrl.irWrite = 1'b1;
          ctrl.pcWrite = 1'b1;  // pc now points at the next instruction.
          nextState = execute;
        end
      end
      execute: begin
        nextState = fetchAddr;
        case (opcode)
          cpuTypes::OP_ADD, cpuTypes::OP_SUB, cpuTypes::OP_AND,
          cpuTypes::OP_OR, cpuTypes::OP_XOR: begin
            ctrl.aluOp = regAluOp;
            ctrl.regWrite = 1'b1;
            ctrl.flagsWrite = 1'b1;
          end
          cpuTypes::OP_ADDI: begin
            ctrl.opBSel = 1'b1;
            ctrl.regWrite = 1'b1;
          end
          cpuTypes::OP_LUI: begin
            ctrl.aluOp = cpuTypes::ALU_PASSB;
            ctrl.opBSel = 1'b1;
            ctrl.immUpper = 1'b1;
            ctrl.regWrite = 1'b1;
          end
          cpuTypes::OP_LDW: nextState = memAddr;
          cpuTypes::OP_STW: begin
            ctrl.mdrWrite = 1'b1;  // latch rs2 for the data phase.
            nextState = memAddr;
          end
          cpuTypes::OP_BR: begin
            ctrl.pcWrite = taken;
            ctrl.pcSel = 1'b1;
          end
          default: ;
        endcase
      end
      memAddr: begin
        ale = 1'b1;
        nMe = 1'b0;
        ctrl.busSel = cpuTypes::BUS_RS1;
        nextState = memData;
      end
      memData: begin
        nMe = 1'b0;
        if (isStore) begin
          rnW = 1'b0;
          enb = 1'b1;
          ctrl.busSel = cpuTypes::BUS_RS2;
        end else begin
          nOe = 1'b0;
        end
        if (nWait) begin
          ctrl.regWrite = !isStore;
          ctrl.wbSel = 1'b1;
          nextState = fetchAddr;
        end
      end
      default: nextState = idle;
    endcase
  end

endmodule

// ==== design/cpuCore.sv ====
// Processor core joining the control unit to the datapath behind the memory bus pins.
`timescale 1ns/1ps

module cpuCore (
  input  logic            Clock,
  input  logic            reset,
  input  cpuTypes::word_t dataIn,
  input  logic            nWait,
  output cpuTypes::word_t dataOut,
  output logic            ale,
  output logic            nMe,
  output logic            nOe,
  output logic            rnW,
  output logic            enb
);

  cpuTypes::controlWord_t ctrl;
  cpuTypes::word_t        instr;
  cpuTypes::flags_t       flags;

  control control (
    .ctrl    (ctrl    ),  // outputs.
    .ale     (ale     ),
    .nMe     (nMe     ),
    .nOe     (nOe     ),
    .rnW     (rnW     ),  // read not write.
    .enb     (enb     ),
    .instr   (instr   ),  // inputs.
    .flags   (flags   ),
    .nWait   (nWait   ),
    .Clock   (Clock   ),
    .reset   (reset   )
  );

  datapath datapath (
    .dataOut (dataOut ),  // outputs.
    .instr   (instr   ),
    .flags   (flags   ),
    .ctrl    (ctrl    ),  // inputs.
    .dataIn  (dataIn  ),
    .Clock   (Clock   ),
    .reset   (reset   )
  );

endmodule

// ==== testbench/memoryModel.sv ====
// Word memory on the multiplexed bus that adds random wait states and reports each write.
`timescale 1ns/1ps

module memoryModel (
  input  logic            Clock,
  input  cpuTypes::word_t addrData,
  input  logic            ale,
  input  logic            nMe,
  input  logic            nOe,
  input  logic            rnW,
  input  logic            enb,
  output cpuTypes::word_t readData,
  output logic            nWait,
  output logic            writeValid,
  output cpuTypes::addr_t writeAddr,
  output cpuTypes::word_t writeData
);

  cpuTypes::word_t mem [0:65535];
  cpuTypes::addr_t addr;
  int              waitLeft;

  task automatic preload(input cpuTypes::addr_t a, input cpuTypes::word_t w);
    mem[a] = w;
  endtask

  // one process handles both edges, so every wait draw follows the single seed.
  initial begin
    void'($urandom(34));
    readData = '0;
    nWait = 1'b1;
    writeValid = 1'b0;
    writeAddr = '0;
    writeData = '0;
    addr = '0;
    waitLeft = 0;
    forever begin
      @(posedge Clock);
      writeValid <= 1'b0;
      if (ale && !nMe) begin
        addr = addrData;  // address phase.
        waitLeft = $urandom % 4;
      end else if (!nMe && !rnW && enb && nWait) begin
        mem[addr] = addrData;
        writeValid <= 1'b1;
        writeAddr <= addr;
        writeData <= addrData;
      end
      @(negedge Clock);
      if (!nMe && !ale) begin
        nWait <= (waitLeft == 0);  // stretch until the count runs out.
        if (waitLeft != 0) begin
          waitLeft = waitLeft - 1;
        end
        readData <= (!nOe && rnW) ? mem[addr] : '0;
      end else begin
        nWait <= 1'b1;
        readData <= '0;
      end
    end
  end

endmodule

// ==== testbench/cpuCoreTb.sv ====
// Testbench for the core, running a program image and checking every bus write.
`timescale 1ns/1ps

module cpuCoreTb;

  typedef struct packed {
    cpuTypes::addr_t addr;
    cpuTypes::word_t data;
  } busWrite_t;

  logic            Clock;
  logic            reset;
  cpuTypes::word_t dataIn;
  logic            nWait;
  cpuTypes::word_t dataOut;
  logic            ale;
  logic            nMe;
  logic            nOe;
  logic            rnW;
  logic            enb;
  logic            writeValid;
  cpuTypes::addr_t writeAddr;
  cpuTypes::word_t writeData;

  busWrite_t expected [$];
  busWrite_t want;
  int        errors;
  int        tests;
  int        errorsBefore;
  int        cycles;
  logic      timedOut;

  cpuCore DUT (
    .Clock   (Clock   ),
    .reset   (reset   ),
    .dataIn  (dataIn  ),
    .nWait   (nWait   ),
    .dataOut (dataOut ),
    .ale     (ale     ),
    .nMe     (nMe     ),
    .nOe     (nOe     ),
    .rnW     (rnW     ),
    .enb     (enb     )
  );

  memoryModel memory (
    .Clock      (Clock      ),
    .addrData   (dataOut    ),
    .ale        (ale        ),
    .nMe        (nMe        ),
    .nOe        (nOe        ),
    .rnW        (rnW        ),
    .enb        (enb        ),
    .readData   (dataIn     ),
    .nWait      (nWait      ),
    .writeValid (writeValid ),
    .writeAddr  (writeAddr  ),
    .writeData  (writeData  )
  );

  always #10 Clock = ~Clock;

  task automatic checkAddr(input cpuTypes::addr_t got, input cpuTypes::addr_t exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at time %0t: write address %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic checkData(input cpuTypes::word_t got, input cpuTypes::word_t exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at time %0t: write data %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic checkIdle();
    if ({ale, nMe, nOe, rnW, enb} !== 5'b01110) begin
      errors++;
      $display("Mismatch at time %0t: bus not idle, ale nMe nOe rnW enb = %b",
               $time, {ale, nMe, nOe, rnW, enb});
    end
  endtask

  task automatic loadVectors();
    int              fd;
    logic [8*80-1:0] line;
    logic [7:0]      kind;
    cpuTypes::addr_t addr;
    cpuTypes::word_t word;
    fd = $fopen("testbench/cpuCore_vectors.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the vectors file");
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        void'($fgets(line, fd));
        if ($sscanf(line, "%s %h %h", kind, addr, word) == 3) begin
          if (kind == "P") begin
            memory.preload(addr, word);
          end else if (kind == "W") begin
            expected.push_back(busWrite_t'({addr, word}));
          end
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    Clock = 1'b0;
    reset = 1'b1;
    errors = 0;
    tests = 0;
    timedOut = 1'b0;
    loadVectors();
    repeat (4) begin
      @(negedge Clock);
      checkIdle();
    end
    reset = 1'b0;
    tests++;
    $display("test %0d bus idle in reset: %s", tests, (errors == 0) ? "ok" : "failed");
    while (expected.size() > 0 && !timedOut) begin
      want = expected.pop_front();
      errorsBefore = errors;
      tests++;
      @(negedge Clock);
      cycles = 1;
      while (!writeValid && cycles < 200) begin
        @(negedge Clock);
        cycles++;
      end
      if (!writeValid) begin
        timedOut = 1'b1;
        errors++;
        $display("test %0d: no write arrived within 200 cycles", tests);
      end else begin
        checkAddr(writeAddr, want.addr);
        checkData(writeData, want.data);
        $display("test %0d write %h to %h: %s", tests, writeData, writeAddr,
                 (errors == errorsBefore) ? "ok" : "failed");
      end
    end
    // the final loop must stop after its last store.
    if (!timedOut) begin
      tests++;
      @(negedge Clock);
      cycles = 1;
      while (!writeValid && cycles < 200) begin
        @(negedge Clock);
        cycles++;
      end
      if (writeValid) begin
        errors++;
        $display("test %0d: unexpected write %h to %h after the last expected write",
                 tests, writeData, writeAddr);
      end else begin
        $display("test %0d no further write: ok", tests);
      end
    end
    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== testbench/cpuCore_vectors.txt ====
# P address word : program or data word preloaded into memory
# W address word : expected bus write, in order
P 0000 6212  # lui r1, 0x12
P 0001 5234  # addi r1, 0x34
P 0002 8048  # stw [r1], r1
P 0003 5480  # addi r2, 0x80
P 0004 8090  # stw [r2], r2
P 0005 0650  # add r3, r1, r2
P 0006 80D8  # stw [r3], r3
P 0007 1850  # sub r4, r1, r2
P 0008 8120  # stw [r4], r4
P 0009 2A50  # and r5, r1, r2
P 000A 8168  # stw [r5], r5
P 000B 3C50  # or r6, r1, r2
P 000C 81B0  # stw [r6], r6
P 000D 4C50  # xor r6, r1, r2
P 000E 81B0  # stw [r6], r6
P 000F 5055  # addi r0, 0x55
P 0010 6402  # lui r2, 0x02
P 0011 7680  # ldw r3, [r2]
P 0012 8058  # stw [r1], r3
P 0013 9802  # br mi, +2
P 0014 8040  # stw [r1], r0
P 0015 9001  # br always, +1
P 0016 8068  # stw [r1], r5
P 0017 9602  # br cs, +2
P 0018 8040  # stw [r1], r0
P 0019 9001  # br always, +1
P 001A 8068  # stw [r1], r5
P 001B 1848  # sub r4, r1, r1
P 001C 9202  # br eq, +2
P 001D 8040  # stw [r1], r0
P 001E 9001  # br always, +1
P 001F 8068  # stw [r1], r5
P 0020 9402  # br ne, +2
P 0021 8040  # stw [r1], r0
P 0022 9001  # br always, +1
P 0023 8068  # stw [r1], r5
P 0024 5803  # addi r4, 3
P 0025 5E01  # addi r7, 1
P 0026 8060  # stw [r1], r4
P 0027 1938  # sub r4, r4, r7
P 0028 94FD  # br ne, -3
P 0029 90FF  # br always, -1
P 0200 BEEF  # load data
W 1234 1234
W FF80 FF80
W 11B4 11B4
W 12B4 12B4
W 1200 1200
W FFB4 FFB4
W EDB4 EDB4
W 1234 BEEF
W 1234 1200
W 1234 0000
W 1234 1200
W 1234 0000
W 1234 0003
W 1234 0002
W 1234 0001

// ==== cpuCore.f ====
+incdir+common
common/cpuTypes.sv
datapath/alu.sv
datapath/registerFile.sv
datapath/datapath.sv
control/control.sv
design/cpuCore.sv
testbench/memoryModel.sv
testbench/cpuCoreTb.sv
